// File: verilog/bus_pkg.sv
// Bus definitions
// Widths and types of the OBI bus and the register bus
package bus_pkg;

  // OBI bus
  // ------------------------------
  localparam int OBI_ADDR_W = 32;
  localparam int OBI_DATA_W = 32;
  localparam int OBI_BE_W   = OBI_DATA_W / 8;

  typedef logic [OBI_ADDR_W-1:0] obi_addr_t;
  typedef logic [OBI_DATA_W-1:0] obi_data_t;
  typedef logic [OBI_BE_W-1:0]   obi_be_t;

  // Register bus
  // ------------------------------
  localparam int REG_ADDR_W = 16;
  localparam int REG_DATA_W = 32;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_DATA_W-1:0] reg_data_t;

endpackage

// File: verilog/map_pkg.sv
// Subsystem map
// Address map, master indices, memory geometry and register offsets
package map_pkg;

  // Memory banks
  localparam int MEM_WORDS    = 1024;
  localparam int MEM_BANK_BIT = 12;
  localparam int MEM_GNT_WAIT = 2;
  localparam int NUM_BANKS    = 2;
  typedef logic [$clog2(MEM_WORDS)-1:0] mem_idx_t;

  // Bus masters
  localparam int NUM_MASTERS = 2;
  typedef logic master_sel_t;
  localparam master_sel_t HOST_IDX = 1'b0;
  localparam master_sel_t DMA_IDX  = 1'b1;

  // Register map
  // ------------------------------
  localparam logic [15:0] DMA_BASE    = 16'h0100;
  localparam logic [15:0] POWER_BASE  = 16'h0200;
  localparam logic [15:0] PERIPH_SPAN = 16'h0100;
  typedef enum logic [1:0] {SEL_DMA, SEL_POWER, SEL_NONE} periph_sel_t;

  localparam logic [7:0] DMA_SRC      = 8'h00;
  localparam logic [7:0] DMA_DST      = 8'h04;
  localparam logic [7:0] DMA_SIZE     = 8'h08;
  localparam logic [7:0] DMA_CTRL     = 8'h0C;
  localparam logic [7:0] POWER_SWITCH = 8'h00;
  localparam logic [7:0] POWER_ACK    = 8'h04;

  // Power domains
  localparam int NUM_DOMAINS        = 3;
  localparam int SWITCH_ACK_LATENCY = 15;
  typedef logic [NUM_DOMAINS-1:0] domain_vec_t;

endpackage

// File: verilog/slow_memory.sv
// Slow memory bank
// Word-addressed RAM with byte enables, grants after a fixed wait
`timescale 1ns/1ns

module slow_memory
  import bus_pkg::*;
  import map_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_i,
  input  logic      we_i,
  input  mem_idx_t  addr_i,
  input  obi_be_t   be_i,
  input  obi_data_t wdata_i,
  output logic      gnt_o,
  output logic      rvalid_o,
  output obi_data_t rdata_o
);

  obi_data_t mem [MEM_WORDS];
  logic [$clog2(MEM_GNT_WAIT+1)-1:0] wait_cnt_q;

  // Grant once the request has been held long enough
  assign gnt_o = req_i && (wait_cnt_q == MEM_GNT_WAIT);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wait_cnt_q <= '0;
      rvalid_o   <= 1'b0;
    end else begin
      rvalid_o <= gnt_o;
      if (req_i && !gnt_o) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end else begin
        wait_cnt_q <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      if (we_i) begin
        for (int i = 0; i < $bits(obi_be_t); i++) begin
          if (be_i[i]) mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// File: verilog/ext_bus.sv
// External bus crossbar
// Routes host and DMA masters to two memory banks with round-robin arbitration
`timescale 1ns/1ns

module ext_bus
  import bus_pkg::*;
  import map_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Host master
  input  logic      host_req_i,
  input  obi_addr_t host_addr_i,
  input  logic      host_we_i,
  input  obi_be_t   host_be_i,
  input  obi_data_t host_wdata_i,
  output logic      host_gnt_o,
  output logic      host_rvalid_o,
  output obi_data_t host_rdata_o,
  // DMA master
  input  logic      dma_req_i,
  input  obi_addr_t dma_addr_i,
  input  logic      dma_we_i,
  input  obi_be_t   dma_be_i,
  input  obi_data_t dma_wdata_i,
  output logic      dma_gnt_o,
  output logic      dma_rvalid_o,
  output obi_data_t dma_rdata_o,
  // Bank 0
  output logic      mem0_req_o,
  output mem_idx_t  mem0_idx_o,
  output logic      mem0_we_o,
  output obi_be_t   mem0_be_o,
  output obi_data_t mem0_wdata_o,
  input  logic      mem0_gnt_i,
  input  logic      mem0_rvalid_i,
  input  obi_data_t mem0_rdata_i,
  // Bank 1
  output logic      mem1_req_o,
  output mem_idx_t  mem1_idx_o,
  output logic      mem1_we_o,
  output obi_be_t   mem1_be_o,
  output obi_data_t mem1_wdata_o,
  input  logic      mem1_gnt_i,
  input  logic      mem1_rvalid_i,
  input  obi_data_t mem1_rdata_i
);

  logic        m_req    [NUM_MASTERS];
  obi_addr_t   m_addr   [NUM_MASTERS];
  logic        m_we     [NUM_MASTERS];
  obi_be_t     m_be     [NUM_MASTERS];
  obi_data_t   m_wdata  [NUM_MASTERS];
  logic        m_gnt    [NUM_MASTERS];
  logic        m_rvalid [NUM_MASTERS];
  obi_data_t   m_rdata  [NUM_MASTERS];
  logic        b_gnt    [NUM_BANKS];
  logic        b_rvalid [NUM_BANKS];
  obi_data_t   b_rdata  [NUM_BANKS];
  logic        b_req    [NUM_BANKS];
  master_sel_t cur_sel  [NUM_BANKS];
  master_sel_t rsp_sel  [NUM_BANKS];

  assign m_req[HOST_IDX]   = host_req_i;
  assign m_addr[HOST_IDX]  = host_addr_i;
  assign m_we[HOST_IDX]    = host_we_i;
  assign m_be[HOST_IDX]    = host_be_i;
  assign m_wdata[HOST_IDX] = host_wdata_i;
  assign m_req[DMA_IDX]    = dma_req_i;
  assign m_addr[DMA_IDX]   = dma_addr_i;
  assign m_we[DMA_IDX]     = dma_we_i;
  assign m_be[DMA_IDX]     = dma_be_i;
  assign m_wdata[DMA_IDX]  = dma_wdata_i;

  assign b_gnt[0]    = mem0_gnt_i;
  assign b_rvalid[0] = mem0_rvalid_i;
  assign b_rdata[0]  = mem0_rdata_i;
  assign b_gnt[1]    = mem1_gnt_i;
  assign b_rvalid[1] = mem1_rvalid_i;
  assign b_rdata[1]  = mem1_rdata_i;

  // Per-bank arbitration
  // ------------------------------
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic [NUM_MASTERS-1:0] want;
    master_sel_t pick;
    master_sel_t owner_q;
    master_sel_t last_q;
    master_sel_t rsp_q;
    logic        locked_q;

    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_want
      assign want[m] = m_req[m] && (m_addr[m][MEM_BANK_BIT] == 1'(b));
    end

    // Owner stays locked until its grant, ties go away from the last winner
    always_comb begin
      if (locked_q) begin
        pick = owner_q;
      end else if (want[HOST_IDX] && want[DMA_IDX]) begin
        pick = ~last_q;
      end else if (want[DMA_IDX]) begin
        pick = DMA_IDX;
      end else begin
        pick = HOST_IDX;
      end
    end

    assign b_req[b]   = want[pick];
    assign cur_sel[b] = pick;
    assign rsp_sel[b] = rsp_q;

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        locked_q <= 1'b0;
        owner_q  <= HOST_IDX;
        last_q   <= HOST_IDX;
        rsp_q    <= HOST_IDX;
      end else if (b_req[b]) begin
        if (b_gnt[b]) begin
          locked_q <= 1'b0;
          last_q   <= pick;
          rsp_q    <= pick;
        end else begin
          locked_q <= 1'b1;
          owner_q  <= pick;
        end
      end
    end
  end

  assign mem0_req_o   = b_req[0];
  assign mem0_idx_o   = m_addr[cur_sel[0]][MEM_BANK_BIT-1:2];
  assign mem0_we_o    = m_we[cur_sel[0]];
  assign mem0_be_o    = m_be[cur_sel[0]];
  assign mem0_wdata_o = m_wdata[cur_sel[0]];
  assign mem1_req_o   = b_req[1];
  assign mem1_idx_o   = m_addr[cur_sel[1]][MEM_BANK_BIT-1:2];
  assign mem1_we_o    = m_we[cur_sel[1]];
  assign mem1_be_o    = m_be[cur_sel[1]];
  assign mem1_wdata_o = m_wdata[cur_sel[1]];

  // Grant and response routing back to the masters
  always_comb begin
    for (int m = 0; m < NUM_MASTERS; m++) begin
      m_gnt[m]    = 1'b0;
      m_rvalid[m] = 1'b0;
      m_rdata[m]  = '0;
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (b_gnt[b] && cur_sel[b] == master_sel_t'(m)) m_gnt[m] = 1'b1;
        if (b_rvalid[b] && rsp_sel[b] == master_sel_t'(m)) begin
          m_rvalid[m] = 1'b1;
          m_rdata[m]  = b_rdata[b];
        end
      end
    end
  end

  assign host_gnt_o    = m_gnt[HOST_IDX];
  assign host_rvalid_o = m_rvalid[HOST_IDX];
  assign host_rdata_o  = m_rdata[HOST_IDX];
  assign dma_gnt_o     = m_gnt[DMA_IDX];
  assign dma_rvalid_o  = m_rvalid[DMA_IDX];
  assign dma_rdata_o   = m_rdata[DMA_IDX];

endmodule

// File: verilog/reg_demux.sv
// Register bus demultiplexer
// Decodes the register address to a peripheral and muxes the reply
`timescale 1ns/1ns

module reg_demux
  import bus_pkg::*;
  import map_pkg::*;
(
  input  logic       reg_valid_i,
  input  logic       reg_write_i,
  input  reg_addr_t  reg_addr_i,
  input  reg_data_t  reg_wdata_i,
  output logic       reg_ready_o,
  output reg_data_t  reg_rdata_o,
  output logic       reg_error_o,
  output logic       dma_valid_o,
  output logic       power_valid_o,
  output logic       periph_write_o,
  output logic [7:0] periph_offset_o,
  output reg_data_t  periph_wdata_o,
  input  reg_data_t  dma_rdata_i,
  input  reg_data_t  power_rdata_i
);

  periph_sel_t sel;

  always_comb begin
    if (reg_addr_i >= DMA_BASE && reg_addr_i < DMA_BASE + PERIPH_SPAN) begin
      sel = SEL_DMA;
    end else if (reg_addr_i >= POWER_BASE && reg_addr_i < POWER_BASE + PERIPH_SPAN) begin
      sel = SEL_POWER;
    end else begin
      sel = SEL_NONE;
    end
  end

  assign dma_valid_o     = reg_valid_i && (sel == SEL_DMA);
  assign power_valid_o   = reg_valid_i && (sel == SEL_POWER);
  assign periph_write_o  = reg_write_i;
  assign periph_offset_o = reg_addr_i[7:0];
  assign periph_wdata_o  = reg_wdata_i;

  // Peripherals answer in the same cycle
  assign reg_ready_o = reg_valid_i;
  assign reg_error_o = reg_valid_i && (sel == SEL_NONE);
  assign reg_rdata_o = (sel == SEL_DMA)   ? dma_rdata_i :
                       (sel == SEL_POWER) ? power_rdata_i : '0;

endmodule

// File: verilog/memcopy_dma.sv
// Memcopy DMA
// Register block and engine that copies words over the OBI bus
`timescale 1ns/1ns

module memcopy_dma
  import bus_pkg::*;
  import map_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       reg_valid_i,
  input  logic       reg_write_i,
  input  logic [7:0] reg_offset_i,
  input  reg_data_t  reg_wdata_i,
  output reg_data_t  reg_rdata_o,
  output logic       obi_req_o,
  output obi_addr_t  obi_addr_o,
  output logic       obi_we_o,
  output obi_be_t    obi_be_o,
  output obi_data_t  obi_wdata_o,
  input  logic       obi_gnt_i,
  input  logic       obi_rvalid_i,
  input  obi_data_t  obi_rdata_i,
  output logic       dma_intr_o
);

  typedef enum logic [2:0] {
    IDLE,
    READ_REQ,
    READ_WAIT,
    WRITE_REQ,
    WRITE_WAIT,
    DONE
  } state_e;

  state_e    state_q;
  obi_addr_t src_q;
  obi_addr_t dst_q;
  reg_data_t size_q;
  reg_data_t cnt_q;
  obi_data_t buf_q;
  logic      busy;
  logic      reg_wr;
  logic      start;
  logic      clear;

  assign busy   = (state_q != IDLE);
  assign reg_wr = reg_valid_i && reg_write_i;
  assign start  = reg_wr && (reg_offset_i == DMA_CTRL) && reg_wdata_i[0] && !busy;
  assign clear  = reg_wr && (reg_offset_i == DMA_CTRL) && reg_wdata_i[1];

  // Register read
  always_comb begin
    case (reg_offset_i)
      DMA_SRC:  reg_rdata_o = src_q;
      DMA_DST:  reg_rdata_o = dst_q;
      DMA_SIZE: reg_rdata_o = size_q;
      DMA_CTRL: reg_rdata_o = {30'b0, dma_intr_o, busy};
      default:  reg_rdata_o = '0;
    endcase
  end

  // OBI master request
  // ------------------------------
  assign obi_req_o   = (state_q == READ_REQ) || (state_q == WRITE_REQ);
  assign obi_we_o    = (state_q == WRITE_REQ);
  assign obi_be_o    = '1;
  assign obi_wdata_o = buf_q;
  assign obi_addr_o  = (state_q == WRITE_REQ) ? dst_q + {cnt_q[29:0], 2'b00}
                                              : src_q + {cnt_q[29:0], 2'b00};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      src_q      <= '0;
      dst_q      <= '0;
      size_q     <= '0;
      cnt_q      <= '0;
      dma_intr_o <= 1'b0;
    end else begin
      if (reg_wr && !busy) begin
        if (reg_offset_i == DMA_SRC) src_q <= reg_wdata_i;
        if (reg_offset_i == DMA_DST) dst_q <= reg_wdata_i;
        if (reg_offset_i == DMA_SIZE) size_q <= reg_wdata_i;
      end
      if (clear || start) dma_intr_o <= 1'b0;

      case (state_q)
        IDLE: begin
          if (start) begin
            cnt_q   <= '0;
            state_q <= (size_q == '0) ? DONE : READ_REQ;
          end
        end
        READ_REQ: if (obi_gnt_i) state_q <= READ_WAIT;
        READ_WAIT: if (obi_rvalid_i) state_q <= WRITE_REQ;
        WRITE_REQ: if (obi_gnt_i) state_q <= WRITE_WAIT;
        WRITE_WAIT: begin
          if (obi_rvalid_i) begin
            if (cnt_q + 1 == size_q) begin
              dma_intr_o <= 1'b1;
              state_q    <= IDLE;
            end else begin
              cnt_q   <= cnt_q + 1;
              state_q <= READ_REQ;
            end
          end
        end
        DONE: begin
          // Zero-length copy completes at once
          dma_intr_o <= 1'b1;
          state_q    <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == READ_WAIT && obi_rvalid_i) buf_q <= obi_rdata_i;
  end

endmodule

// File: verilog/power_switch_emu.sv
// Power switch emulator
// Switch register and acknowledge delay line for the power domains
`timescale 1ns/1ns

module power_switch_emu
  import bus_pkg::*;
  import map_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        reg_valid_i,
  input  logic        reg_write_i,
  input  logic [7:0]  reg_offset_i,
  input  reg_data_t   reg_wdata_i,
  output reg_data_t   reg_rdata_o,
  output domain_vec_t power_switch_n_o,
  output domain_vec_t power_ack_n_o
);

  domain_vec_t ack_q [SWITCH_ACK_LATENCY+1];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      power_switch_n_o <= '0;
      for (int i = 0; i <= SWITCH_ACK_LATENCY; i++) ack_q[i] <= '0;
    end else begin
      if (reg_valid_i && reg_write_i && reg_offset_i == POWER_SWITCH) begin
        power_switch_n_o <= reg_wdata_i[NUM_DOMAINS-1:0];
      end
      ack_q[0] <= power_switch_n_o;
      for (int i = 1; i <= SWITCH_ACK_LATENCY; i++) ack_q[i] <= ack_q[i-1];
    end
  end

  // Last stage is the acknowledge
  assign power_ack_n_o = ack_q[SWITCH_ACK_LATENCY];

  assign reg_rdata_o =
    (reg_offset_i == POWER_SWITCH) ? {{(32-NUM_DOMAINS){1'b0}}, power_switch_n_o} :
    (reg_offset_i == POWER_ACK)    ? {{(32-NUM_DOMAINS){1'b0}}, power_ack_n_o} : '0;

endmodule

// File: verilog/ext_harness.sv
// External subsystem harness
// Connects the bus, both memory banks, the register demux and the peripherals
`timescale 1ns/1ns

module ext_harness
  import bus_pkg::*;
  import map_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  // Register port
  input  logic        reg_valid_i,
  input  logic        reg_write_i,
  input  reg_addr_t   reg_addr_i,
  input  reg_data_t   reg_wdata_i,
  output logic        reg_ready_o,
  output reg_data_t   reg_rdata_o,
  output logic        reg_error_o,
  // Host OBI port
  input  logic        host_req_i,
  input  obi_addr_t   host_addr_i,
  input  logic        host_we_i,
  input  obi_be_t     host_be_i,
  input  obi_data_t   host_wdata_i,
  output logic        host_gnt_o,
  output logic        host_rvalid_o,
  output obi_data_t   host_rdata_o,
  output logic        dma_intr_o,
  output domain_vec_t power_switch_n_o,
  output domain_vec_t power_ack_n_o
);

  logic       dma_req, dma_we, dma_gnt, dma_rvalid;
  obi_addr_t  dma_addr;
  obi_be_t    dma_be;
  obi_data_t  dma_wdata, dma_rdata;
  logic       mem0_req, mem0_we, mem0_gnt, mem0_rvalid;
  logic       mem1_req, mem1_we, mem1_gnt, mem1_rvalid;
  mem_idx_t   mem0_idx, mem1_idx;
  obi_be_t    mem0_be, mem1_be;
  obi_data_t  mem0_wdata, mem0_rdata, mem1_wdata, mem1_rdata;
  logic       dma_valid, power_valid, periph_write;
  logic [7:0] periph_offset;
  reg_data_t  periph_wdata, dma_reg_rdata, power_reg_rdata;

  // Memory side
  // ------------------------------
  ext_bus u_ext_bus (
    .clk_i, .rst_n_i,
    .host_req_i, .host_addr_i, .host_we_i, .host_be_i, .host_wdata_i,
    .host_gnt_o, .host_rvalid_o, .host_rdata_o,
    .dma_req_i(dma_req), .dma_addr_i(dma_addr), .dma_we_i(dma_we), .dma_be_i(dma_be),
    .dma_wdata_i(dma_wdata), .dma_gnt_o(dma_gnt), .dma_rvalid_o(dma_rvalid),
    .dma_rdata_o(dma_rdata),
    .mem0_req_o(mem0_req), .mem0_idx_o(mem0_idx), .mem0_we_o(mem0_we), .mem0_be_o(mem0_be),
    .mem0_wdata_o(mem0_wdata), .mem0_gnt_i(mem0_gnt), .mem0_rvalid_i(mem0_rvalid),
    .mem0_rdata_i(mem0_rdata),
    .mem1_req_o(mem1_req), .mem1_idx_o(mem1_idx), .mem1_we_o(mem1_we), .mem1_be_o(mem1_be),
    .mem1_wdata_o(mem1_wdata), .mem1_gnt_i(mem1_gnt), .mem1_rvalid_i(mem1_rvalid),
    .mem1_rdata_i(mem1_rdata)
  );

  slow_memory u_mem0 (
    .clk_i, .rst_n_i, .req_i(mem0_req), .we_i(mem0_we), .addr_i(mem0_idx), .be_i(mem0_be),
    .wdata_i(mem0_wdata), .gnt_o(mem0_gnt), .rvalid_o(mem0_rvalid), .rdata_o(mem0_rdata)
  );

  slow_memory u_mem1 (
    .clk_i, .rst_n_i, .req_i(mem1_req), .we_i(mem1_we), .addr_i(mem1_idx), .be_i(mem1_be),
    .wdata_i(mem1_wdata), .gnt_o(mem1_gnt), .rvalid_o(mem1_rvalid), .rdata_o(mem1_rdata)
  );

  // Register side
  // ------------------------------
  reg_demux u_reg_demux (
    .reg_valid_i, .reg_write_i, .reg_addr_i, .reg_wdata_i,
    .reg_ready_o, .reg_rdata_o, .reg_error_o,
    .dma_valid_o(dma_valid), .power_valid_o(power_valid), .periph_write_o(periph_write),
    .periph_offset_o(periph_offset), .periph_wdata_o(periph_wdata),
    .dma_rdata_i(dma_reg_rdata), .power_rdata_i(power_reg_rdata)
  );

  memcopy_dma u_dma (
    .clk_i, .rst_n_i,
    .reg_valid_i(dma_valid), .reg_write_i(periph_write), .reg_offset_i(periph_offset),
    .reg_wdata_i(periph_wdata), .reg_rdata_o(dma_reg_rdata),
    .obi_req_o(dma_req), .obi_addr_o(dma_addr), .obi_we_o(dma_we), .obi_be_o(dma_be),
    .obi_wdata_o(dma_wdata), .obi_gnt_i(dma_gnt), .obi_rvalid_i(dma_rvalid),
    .obi_rdata_i(dma_rdata), .dma_intr_o
  );

  power_switch_emu u_power (
    .clk_i, .rst_n_i,
    .reg_valid_i(power_valid), .reg_write_i(periph_write), .reg_offset_i(periph_offset),
    .reg_wdata_i(periph_wdata), .reg_rdata_o(power_reg_rdata),
    .power_switch_n_o, .power_ack_n_o
  );

endmodule

// File: testbench/tb_clock.sv
// Testbench clock
// Free-running clock with a 10 ns period
`timescale 1ns/1ns

module tb_clock (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #5 clk_o = ~clk_o;

endmodule

// File: testbench/tb_harness.sv
// Subsystem testbench
// Directed tests for host memory access, register decode, DMA copy and power switch
`timescale 1ns/1ns

module tb_harness
  import bus_pkg::*;
  import map_pkg::*;
();

  // Copy of 64 words plus host traffic is about 2000 cycles, other tests about 1500
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int COPY_WORDS     = 64;
  localparam int COPY_SRC_WORD  = 100;
  localparam int COPY_DST_WORD  = 200;
  localparam int INIT_WORDS     = 32;

  logic        clk;
  logic        rst_n;
  logic        reg_valid;
  logic        reg_write;
  reg_addr_t   reg_addr;
  reg_data_t   reg_wdata;
  logic        reg_ready;
  reg_data_t   reg_rdata;
  logic        reg_error;
  logic        host_req;
  obi_addr_t   host_addr;
  logic        host_we;
  obi_be_t     host_be;
  obi_data_t   host_wdata;
  logic        host_gnt;
  logic        host_rvalid;
  obi_data_t   host_rdata;
  logic        dma_intr;
  domain_vec_t power_switch_n;
  domain_vec_t power_ack_n;

  // Reference contents of both banks, indexed by address bits 12:2
  obi_data_t   ref_mem [2*MEM_WORDS];
  logic [31:0] rng_state = 32'd65958;
  int unsigned cycles = 0;

  tb_clock u_clock (.clk_o(clk));

  ext_harness uut (
    .clk_i(clk), .rst_n_i(rst_n),
    .reg_valid_i(reg_valid), .reg_write_i(reg_write), .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata), .reg_ready_o(reg_ready), .reg_rdata_o(reg_rdata),
    .reg_error_o(reg_error),
    .host_req_i(host_req), .host_addr_i(host_addr), .host_we_i(host_we),
    .host_be_i(host_be), .host_wdata_i(host_wdata), .host_gnt_o(host_gnt),
    .host_rvalid_o(host_rvalid), .host_rdata_o(host_rdata),
    .dma_intr_o(dma_intr), .power_switch_n_o(power_switch_n), .power_ack_n_o(power_ack_n)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  // Register bus
  // ------------------------------
  task automatic reg_transfer(input logic write, input reg_addr_t addr, input reg_data_t wdata,
                              output reg_data_t rdata, output logic error);
    @(posedge clk);
    reg_valid <= 1'b1;
    reg_write <= write;
    reg_addr  <= addr;
    reg_wdata <= wdata;
    @(negedge clk);
    require(reg_ready === 1'b1, "register access was not answered with ready");
    rdata = reg_rdata;
    error = reg_error;
    // Write lands on this edge
    @(posedge clk);
    reg_valid <= 1'b0;
    reg_write <= 1'b0;
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    reg_data_t rdata;
    logic      error;
    reg_transfer(1'b1, addr, data, rdata, error);
    compare_value("reg_error_o", error, 1'b0);
  endtask

  task automatic verify_reg_read(input reg_addr_t addr, input reg_data_t exp,
                                 input logic exp_error);
    reg_data_t rdata;
    logic      error;
    reg_transfer(1'b0, addr, '0, rdata, error);
    compare_value($sformatf("reg_error_o @%h", addr), error, exp_error);
    compare_value($sformatf("reg_rdata_o @%h", addr), rdata, exp);
  endtask

  // Host OBI port
  // ------------------------------
  task automatic host_transfer(input logic write, input obi_addr_t addr, input obi_be_t be,
                               input obi_data_t wdata, output obi_data_t rdata);
    @(posedge clk);
    host_req   <= 1'b1;
    host_we    <= write;
    host_addr  <= addr;
    host_be    <= be;
    host_wdata <= wdata;
    @(negedge clk);
    while (host_gnt !== 1'b1) @(negedge clk);
    @(posedge clk);
    host_req <= 1'b0;
    host_we  <= 1'b0;
    @(negedge clk);
    require(host_rvalid === 1'b1, "host rvalid did not follow its grant by one cycle");
    rdata = host_rdata;
  endtask

  task automatic host_write(input obi_addr_t addr, input obi_be_t be, input obi_data_t data);
    obi_data_t unused;
    host_transfer(1'b1, addr, be, data, unused);
    for (int i = 0; i < 4; i++) begin
      if (be[i]) ref_mem[addr[MEM_BANK_BIT:2]][8*i +: 8] = data[8*i +: 8];
    end
  endtask

  task automatic verify_host_read(input obi_addr_t addr);
    obi_data_t got;
    host_transfer(1'b0, addr, 4'hF, '0, got);
    compare_value($sformatf("host_rdata_o @%h", addr), got, ref_mem[addr[MEM_BANK_BIT:2]]);
  endtask

  // Tests
  // ------------------------------
  task automatic reset_values();
    @(negedge clk);
    compare_value("dma_intr_o", dma_intr, 1'b0);
    compare_value("power_switch_n_o", power_switch_n, 3'b000);
    compare_value("power_ack_n_o", power_ack_n, 3'b000);
    compare_value("host_rvalid_o", host_rvalid, 1'b0);
    verify_reg_read(DMA_BASE + DMA_CTRL, 32'h0, 1'b0);
  endtask

  task automatic host_memory();
    obi_addr_t addr;
    logic [31:0] r;
    for (int bank = 0; bank < 2; bank++) begin
      for (int w = 0; w < INIT_WORDS; w++) begin
        host_write(obi_addr_t'((bank << MEM_BANK_BIT) + 4 * w), 4'hF, next_random());
      end
    end
    // Partial writes over the initialized words
    for (int k = 0; k < 16; k++) begin
      r = next_random();
      addr = obi_addr_t'(((k % 2) << MEM_BANK_BIT) + 4 * (r[12:8] % INIT_WORDS));
      host_write(addr, r[3:0], next_random());
    end
    for (int bank = 0; bank < 2; bank++) begin
      for (int w = 0; w < INIT_WORDS; w++) begin
        verify_host_read(obi_addr_t'((bank << MEM_BANK_BIT) + 4 * w));
      end
    end
  endtask

  task automatic register_decode();
    reg_data_t vals [3];
    for (int i = 0; i < 3; i++) begin
      vals[i] = next_random();
      write_reg(reg_addr_t'(DMA_BASE + 4 * i), vals[i]);
    end
    for (int i = 0; i < 3; i++) begin
      verify_reg_read(reg_addr_t'(DMA_BASE + 4 * i), vals[i], 1'b0);
    end
    verify_reg_read(16'h0000, 32'h0, 1'b1);
    verify_reg_read(16'h0300, 32'h0, 1'b1);
    verify_reg_read(DMA_BASE + 16'h0010, 32'h0, 1'b0);
    verify_reg_read(POWER_BASE + 16'h0008, 32'h0, 1'b0);
  endtask

  task automatic dma_copy();
    obi_addr_t   src;
    obi_addr_t   dst;
    int          reads;
    int unsigned start_cycle;
    src = obi_addr_t'(4 * COPY_SRC_WORD);
    dst = obi_addr_t'((1 << MEM_BANK_BIT) + 4 * COPY_DST_WORD);
    for (int i = 0; i < COPY_WORDS; i++) host_write(src + 4 * i, 4'hF, next_random());
    write_reg(DMA_BASE + DMA_SRC, src);
    write_reg(DMA_BASE + DMA_DST, dst);
    write_reg(DMA_BASE + DMA_SIZE, COPY_WORDS);
    write_reg(DMA_BASE + DMA_CTRL, 32'h1);
    start_cycle = cycles;
    // Host keeps bank 1 busy below the destination words
    reads = 0;
    while (dma_intr !== 1'b1) begin
      verify_host_read(obi_addr_t'((1 << MEM_BANK_BIT) + 4 * (reads % INIT_WORDS)));
      reads++;
    end
    // Every word needs a granted read and a granted write, each followed by rvalid
    require(cycles - start_cycle >= COPY_WORDS * 2 * (MEM_GNT_WAIT + 2),
            "DMA copy finished sooner than the bank grant wait allows");
    for (int i = 0; i < COPY_WORDS; i++) begin
      ref_mem[MEM_WORDS + COPY_DST_WORD + i] = ref_mem[COPY_SRC_WORD + i];
    end
    for (int i = 0; i < COPY_WORDS; i++) verify_host_read(dst + 4 * i);
    verify_reg_read(DMA_BASE + DMA_CTRL, 32'h2, 1'b0);
    write_reg(DMA_BASE + DMA_CTRL, 32'h2);
    @(negedge clk);
    compare_value("dma_intr_o", dma_intr, 1'b0);

    // Zero-length copy
    write_reg(DMA_BASE + DMA_SIZE, 32'h0);
    write_reg(DMA_BASE + DMA_CTRL, 32'h1);
    @(negedge clk);
    compare_value("dma_intr_o", dma_intr, 1'b0);
    @(negedge clk);
    compare_value("dma_intr_o", dma_intr, 1'b1);
    write_reg(DMA_BASE + DMA_CTRL, 32'h2);
  endtask

  task automatic power_switch_delay();
    domain_vec_t old_v;
    domain_vec_t new_v;
    for (int n = 0; n < 2; n++) begin
      old_v = power_ack_n;
      new_v = domain_vec_t'(next_random());
      if (new_v == old_v) new_v = ~old_v;
      write_reg(POWER_BASE + POWER_SWITCH, reg_data_t'(new_v));
      @(negedge clk);
      compare_value("power_switch_n_o", power_switch_n, new_v);
      compare_value("power_ack_n_o", power_ack_n, old_v);
      for (int k = 1; k <= SWITCH_ACK_LATENCY + 1; k++) begin
        @(negedge clk);
        compare_value($sformatf("power_ack_n_o edge %0d", k), power_ack_n,
                      (k == SWITCH_ACK_LATENCY + 1) ? new_v : old_v);
      end
      verify_reg_read(POWER_BASE + POWER_ACK, reg_data_t'(new_v), 1'b0);
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    reg_valid  = 1'b0;
    reg_write  = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    host_req   = 1'b0;
    host_addr  = '0;
    host_we    = 1'b0;
    host_be    = '0;
    host_wdata = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    reset_values();
    host_memory();
    register_decode();
    dma_copy();
    power_switch_delay();

    $display("All checks passed");
    $finish;
  end

endmodule

// File: project.f
verilog/bus_pkg.sv
verilog/map_pkg.sv
verilog/slow_memory.sv
verilog/ext_bus.sv
verilog/reg_demux.sv
verilog/memcopy_dma.sv
verilog/power_switch_emu.sv
verilog/ext_harness.sv
testbench/tb_clock.sv
testbench/tb_harness.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_harness -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_harness)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  exit 1
fi
if echo "$output" | grep -q "All checks passed"; then
  exit 0
fi
exit 1
